// ==== project.f ====
source/debug_types_pkg.sv
source/probe_if.sv
source/clock_controller.sv
source/probe_select.sv
source/display_controller.sv
source/debug_display_top.sv
test/tb_debug_display.sv

// ==== test/tb_debug_display.sv ====
`timescale 1ns/1ps

module tb_debug_display;

    localparam int scan_period = debug_types_pkg::scan_divide;
    localparam int digit_wait  = 2 * debug_types_pkg::scan_divide;

    // DUT inputs
    logic                   clock_100MHz;
    logic                   rst_n;
    logic                   button;
    logic [3:0]             sel_display;
    debug_types_pkg::word_t pc;
    debug_types_pkg::word_t instruction;
    debug_types_pkg::word_t alu_out;
    debug_types_pkg::word_t dmem_wd;
    debug_types_pkg::word_t rf_rd2;
    debug_types_pkg::half_t gpio_out;

    // DUT outputs
    logic       step;
    logic [7:0] sel_led;
    logic [7:0] led_value;

    // Bookkeeping
    logic [31:0] lfsr_state;
    logic [7:0]  seg_table [0:15];
    int          checks      = 0;
    int          errors      = 0;
    int          timeouts    = 0;
    int          cycle_count = 0;
    int          step_rises  = 0;
    int          step_high   = 0;
    logic        step_seen   = 1'b0;

    debug_display_top dut_i (
        .clock_100MHz (clock_100MHz),
        .rst_n        (rst_n),
        .button       (button),
        .sel_display  (sel_display),
        .pc           (pc),
        .instruction  (instruction),
        .alu_out      (alu_out),
        .dmem_wd      (dmem_wd),
        .rf_rd2       (rf_rd2),
        .gpio_out     (gpio_out),
        .step         (step),
        .sel_led      (sel_led),
        .led_value    (led_value)
    );

    //////////////////////////////////////////////////
    // Clock and monitors
    //////////////////////////////////////////////////

    always #10 clock_100MHz = ~clock_100MHz;

    // Free running cycle stamp, read on falling edges
    always @(posedge clock_100MHz) begin
        cycle_count <= cycle_count + 1;
    end

    // Step pulses and their width, pre-edge value of step
    always @(posedge clock_100MHz) begin
        if (step) begin
            step_high <= step_high + 1;
        end
        if (step && !step_seen) begin
            step_rises <= step_rises + 1;
        end
        step_seen <= step;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic randomize_probes();
        logic [31:0] bits;
        draw_bits(32, pc);
        draw_bits(32, instruction);
        draw_bits(32, alu_out);
        draw_bits(32, dmem_wd);
        draw_bits(32, rf_rd2);
        draw_bits(16, bits);
        gpio_out = bits[15:0];
    endtask

    // Active low patterns, dp off, bits 6..0 are g..a
    task automatic load_segment_table();
        seg_table[0]  = 8'hC0;
        seg_table[1]  = 8'hF9;
        seg_table[2]  = 8'hA4;
        seg_table[3]  = 8'hB0;
        seg_table[4]  = 8'h99;
        seg_table[5]  = 8'h92;
        seg_table[6]  = 8'h82;
        seg_table[7]  = 8'hF8;
        seg_table[8]  = 8'h80;
        seg_table[9]  = 8'h90;
        seg_table[10] = 8'h88;
        seg_table[11] = 8'h83;
        seg_table[12] = 8'hC6;
        seg_table[13] = 8'hA1;
        seg_table[14] = 8'h86;
        seg_table[15] = 8'h8E;
    endtask

    // Nibble a digit should show for a display mode
    function automatic logic [3:0] expected_nibble(input logic [3:0] mode, input int digit);
        logic [15:0] right;
        case (mode)
            4'd0:    right = rf_rd2[15:0];
            4'd1:    right = rf_rd2[31:16];
            4'd2:    right = instruction[15:0];
            4'd3:    right = instruction[31:16];
            4'd4:    right = alu_out[15:0];
            4'd5:    right = alu_out[31:16];
            4'd6:    right = dmem_wd[15:0];
            4'd7:    right = dmem_wd[31:16];
            default: right = gpio_out;
        endcase
        if (digit >= 4) begin
            return pc[4*(digit-4) +: 4];
        end
        return right[4*digit +: 4];
    endfunction

    // Lowest enabled digit, -1 if none
    function automatic int selected_digit(input logic [7:0] enables);
        for (int i = 0; i < 8; i++) begin
            if (!enables[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int low_bit_count(input logic [7:0] enables);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            if (!enables[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED t=%0t %s expected %h actual %h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // Called on a falling edge, returns on one
    task automatic wait_for_digit(input int digit);
        logic [7:0] target;
        int         count;
        target = ~(8'b0000_0001 << digit);
        count  = 0;
        while (sel_led !== target && count < digit_wait) begin
            @(negedge clock_100MHz);
            count++;
        end
        if (sel_led !== target) begin
            $display("Timeout at %0t, digit %0d was never enabled", $time, digit);
            timeouts++;
        end
    endtask

    task automatic wait_for_change(input logic [7:0] previous);
        int count;
        count = 0;
        while (sel_led === previous && count < digit_wait) begin
            @(negedge clock_100MHz);
            count++;
        end
        if (sel_led === previous) begin
            $display("Timeout at %0t, digit enable did not move", $time);
            timeouts++;
        end
    endtask

    // Walk one full scan starting at the enabled digit
    task automatic check_all_digits(input logic [3:0] mode);
        int first;
        int digit;
        first = selected_digit(sel_led);
        if (first < 0) begin
            $display("No digit enabled at %0t in mode %0d", $time, mode);
            errors++;
            return;
        end
        for (int k = 0; k < 8; k++) begin
            digit = (first + k) % 8;
            if (k > 0) begin
                wait_for_digit(digit);
            end
            check_value($sformatf("led_value mode %0d digit %0d", mode, digit),
                        seg_table[expected_nibble(mode, digit)], led_value);
        end
    endtask

    task automatic show_mode(input logic [3:0] mode);
        @(negedge clock_100MHz);
        sel_display = mode;
        randomize_probes();
        // Segments pick up new probes one cycle later
        @(negedge clock_100MHz);
        check_all_digits(mode);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        check_value("step", 1'b0, step);
        check_value("sel_led", 8'b1111_1110, sel_led);
        check_value("led_value", seg_table[expected_nibble(sel_display, 0)], led_value);
    endtask

    task automatic test_scan_order();
        logic [7:0] previous;
        int         prev_digit;
        int         prev_time;
        previous   = sel_led;
        prev_digit = selected_digit(sel_led);
        prev_time  = 0;
        for (int k = 0; k < 9; k++) begin
            wait_for_change(previous);
            check_value("sel_led low bits", 1, low_bit_count(sel_led));
            check_value("sel_led digit", (prev_digit + 1) % 8, selected_digit(sel_led));
            // First change has no reference point
            if (k > 0) begin
                check_value("scan interval", scan_period, cycle_count - prev_time);
            end
            prev_time  = cycle_count;
            previous   = sel_led;
            prev_digit = selected_digit(sel_led);
        end
    endtask

    task automatic test_probe_modes();
        for (int m = 0; m < 8; m++) begin
            show_mode(m[3:0]);
        end
    endtask

    task automatic test_gpio_modes();
        show_mode(4'd8);
        show_mode(4'd15);
    endtask

    // Button high for a fixed number of scan periods, then low
    task automatic press_button(input int held, input int released);
        @(negedge clock_100MHz);
        button = 1'b1;
        for (int i = 0; i < held * scan_period; i++) begin
            @(negedge clock_100MHz);
        end
        button = 1'b0;
        for (int i = 0; i < released * scan_period; i++) begin
            @(negedge clock_100MHz);
        end
    endtask

    task automatic test_short_press();
        int rises_before;
        rises_before = step_rises;
        press_button(2, 8);
        check_value("step pulses on short press", 0, step_rises - rises_before);
    endtask

    task automatic test_long_press();
        int rises_before;
        int high_before;
        rises_before = step_rises;
        high_before  = step_high;
        press_button(8, 8);
        check_value("step pulses on long press", 1, step_rises - rises_before);
        check_value("step width", 1, step_high - high_before);
    endtask

    //////////////////////////////////////////////////
    // Sequence
    //////////////////////////////////////////////////

    initial begin
        clock_100MHz = 1'b0;
        rst_n        = 1'b0;
        button       = 1'b0;
        sel_display  = 4'd0;
        pc           = '0;
        instruction  = '0;
        alu_out      = '0;
        dmem_wd      = '0;
        rf_rd2       = '0;
        gpio_out     = '0;
        lfsr_state   = 32'd78016;
        load_segment_table();
        randomize_probes();

        // Three clocks in reset, release away from the edge
        repeat (3) @(posedge clock_100MHz);
        @(negedge clock_100MHz);
        rst_n = 1'b1;
        @(negedge clock_100MHz);

        test_reset();
        test_scan_order();
        test_probe_modes();
        test_gpio_modes();
        test_short_press();
        test_long_press();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== source/debug_display_top.sv ====
`timescale 1ns/1ps

module debug_display_top (
    input  logic                    clock_100MHz,
    input  logic                    rst_n,
    input  logic                    button,
    input  logic [3:0]              sel_display,     // Probe mode for the right half
    input  debug_types_pkg::word_t  pc,
    input  debug_types_pkg::word_t  instruction,
    input  debug_types_pkg::word_t  alu_out,
    input  debug_types_pkg::word_t  dmem_wd,
    input  debug_types_pkg::word_t  rf_rd2,
    input  debug_types_pkg::half_t  gpio_out,
    output logic                    step,            // One pulse per debounced press
    output logic [7:0]              sel_led,
    output logic [7:0]              led_value
);

    logic scan_tick;
    debug_types_pkg::digit_array_t digits;

    //////////////////////////////////////////////////
    // Processor probes
    //////////////////////////////////////////////////

    probe_if probe_i ();

    assign probe_i.pc          = pc;
    assign probe_i.instruction = instruction;
    assign probe_i.alu_out     = alu_out;
    assign probe_i.dmem_wd     = dmem_wd;
    assign probe_i.rf_rd2      = rf_rd2;
    assign probe_i.gpio_out    = gpio_out;

    //////////////////////////////////////////////////
    // Debug display blocks
    //////////////////////////////////////////////////

    // Scan strobe and step button
    clock_controller clock_controller_i (
        .clock_100MHz (clock_100MHz),
        .rst_n        (rst_n),
        .button       (button),
        .scan_tick    (scan_tick),
        .step         (step)
    );

    // Picks the nibbles for all eight digits
    probe_select probe_select_i (
        .probe        (probe_i),
        .sel_display  (sel_display),
        .digits       (digits)
    );

    // Drives the multiplexed seven-segment pins
    display_controller display_controller_i (
        .clock_100MHz (clock_100MHz),
        .rst_n        (rst_n),
        .scan_tick    (scan_tick),
        .digits       (digits),
        .sel_led      (sel_led),
        .led_value    (led_value)
    );

endmodule

// ==== source/display_controller.sv ====
`timescale 1ns/1ps

module display_controller (
    input  logic                           clock_100MHz,
    input  logic                           rst_n,
    input  logic                           scan_tick,
    input  debug_types_pkg::digit_array_t  digits,
    output logic [7:0]                     sel_led,
    output logic [7:0]                     led_value
);

    logic [debug_types_pkg::digit_index_w-1:0] digit_idx;
    logic [debug_types_pkg::digit_index_w-1:0] digit_idx_next;

    //////////////////////////////////////////////////
    // Digit scan
    //////////////////////////////////////////////////

    // Step to the next digit on each tick, wrap after the last
    always_comb begin
        if (!scan_tick) begin
            digit_idx_next = digit_idx;
        end else if (digit_idx == debug_types_pkg::digit_index_w'(
                                     debug_types_pkg::num_digits - 1)) begin
            digit_idx_next = '0;
        end else begin
            digit_idx_next = digit_idx + 1'b1;
        end
    end

    always_ff @(posedge clock_100MHz) begin
        if (!rst_n) begin
            digit_idx <= '0;
        end else begin
            digit_idx <= digit_idx_next;
        end
    end

    //////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////

    // Enable and segments load on the same edge so no digit ghosts
    always_ff @(posedge clock_100MHz) begin
        if (!rst_n) begin
            // Digit 0 on, active low
            sel_led <= 8'b1111_1110;
        end else begin
            sel_led <= ~(8'b0000_0001 << digit_idx_next);
        end
    end

    // Segments track the live nibble, one cycle behind
    always_ff @(posedge clock_100MHz) begin
        if (!rst_n) begin
            led_value <= debug_types_pkg::segment_code(digits[0]);
        end else begin
            led_value <= debug_types_pkg::segment_code(digits[digit_idx_next]);
        end
    end

endmodule

// ==== source/probe_select.sv ====
`timescale 1ns/1ps

module probe_select (
    probe_if.sink                          probe,
    input  logic [3:0]                     sel_display,
    output debug_types_pkg::digit_array_t  digits
);

    // Value shown on the right half of the display
    debug_types_pkg::half_t display_right;

    //////////////////////////////////////////////////
    // Display mode multiplexer
    //////////////////////////////////////////////////

    always_comb begin
        case (sel_display)
            4'd0:    display_right = probe.rf_rd2[15:0];
            4'd1:    display_right = probe.rf_rd2[31:16];
            4'd2:    display_right = probe.instruction[15:0];
            4'd3:    display_right = probe.instruction[31:16];
            4'd4:    display_right = probe.alu_out[15:0];
            4'd5:    display_right = probe.alu_out[31:16];
            4'd6:    display_right = probe.dmem_wd[15:0];
            4'd7:    display_right = probe.dmem_wd[31:16];
            // Upper half of the mode range all show GPIO
            default: display_right = probe.gpio_out;
        endcase
    end

    //////////////////////////////////////////////////
    // Nibble array
    //////////////////////////////////////////////////

    // Right half from the selected value, left half from pc[15:0]
    always_comb begin
        for (int i = 0; i < debug_types_pkg::num_digits / 2; i++) begin
            digits[i] = display_right[4*i +: 4];
            digits[i + debug_types_pkg::num_digits / 2] = probe.pc[4*i +: 4];
        end
    end

endmodule

// ==== source/clock_controller.sv ====
`timescale 1ns/1ps

module clock_controller (
    input  logic clock_100MHz,
    input  logic rst_n,
    input  logic button,
    output logic scan_tick,
    output logic step
);

    logic [debug_types_pkg::scan_count_w-1:0] scan_cnt;

    logic button_meta;
    logic button_sync;
    logic [debug_types_pkg::debounce_samples-1:0] samples;

    logic db_level;
    logic db_prev;

    //////////////////////////////////////////////////
    // Scan strobe divider
    //////////////////////////////////////////////////

    // Down counter, one tick per wrap
    always_ff @(posedge clock_100MHz) begin
        if (!rst_n) begin
            scan_cnt  <= debug_types_pkg::scan_reload;
            scan_tick <= 1'b0;
        end else if (scan_cnt == '0) begin
            scan_cnt  <= debug_types_pkg::scan_reload;
            scan_tick <= 1'b1;
        end else begin
            scan_cnt  <= scan_cnt - 1'b1;
            scan_tick <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Button debounce
    //////////////////////////////////////////////////

    // Two-flop synchronizer for the raw pin
    always_ff @(posedge clock_100MHz) begin
        if (!rst_n) begin
            button_meta <= 1'b0;
            button_sync <= 1'b0;
        end else begin
            button_meta <= button;
            button_sync <= button_meta;
        end
    end

    // History of the last few samples, one per scan tick
    always_ff @(posedge clock_100MHz) begin
        if (!rst_n) begin
            samples <= '0;
        end else if (scan_tick) begin
            samples <= {samples[debug_types_pkg::debounce_samples-2:0], button_sync};
        end
    end

    // Level flips only when the whole history disagrees with it
    always_ff @(posedge clock_100MHz) begin
        if (!rst_n) begin
            db_level <= 1'b0;
        end else if (!db_level && (&samples)) begin
            db_level <= 1'b1;
        end else if (db_level && !(|samples)) begin
            db_level <= 1'b0;
        end
    end

    // Rising edge of the clean level gives a single step
    always_ff @(posedge clock_100MHz) begin
        if (!rst_n) begin
            db_prev <= 1'b0;
            step    <= 1'b0;
        end else begin
            db_prev <= db_level;
            step    <= db_level & ~db_prev;
        end
    end

endmodule

// ==== source/probe_if.sv ====
`timescale 1ns/1ps

interface probe_if;

    // Program counter and fetched instruction
    debug_types_pkg::word_t pc;
    debug_types_pkg::word_t instruction;

    // Datapath probes
    debug_types_pkg::word_t alu_out;
    debug_types_pkg::word_t dmem_wd;
    debug_types_pkg::word_t rf_rd2;

    // Low half of the GPIO output port
    debug_types_pkg::half_t gpio_out;

    // Display side only reads the probes
    modport sink (
        input pc,
        input instruction,
        input alu_out,
        input dmem_wd,
        input rf_rd2,
        input gpio_out
    );

endinterface

// ==== source/debug_types_pkg.sv ====
package debug_types_pkg;

    // Probe bus widths
    typedef logic [31:0] word_t;
    typedef logic [15:0] half_t;
    typedef logic [3:0]  nibble_t;

    //////////////////////////////////////////////////
    // Display geometry
    //////////////////////////////////////////////////

    localparam int num_digits    = 8;
    localparam int digit_index_w = $clog2(num_digits);

    // Index 0 is the rightmost digit
    typedef nibble_t digit_array_t [0:num_digits-1];

    // 100 MHz board clock down to a 5 kHz scan rate
    localparam int scan_divide  = 20000;
    localparam int scan_count_w = $clog2(scan_divide);
    localparam logic [scan_count_w-1:0] scan_reload = scan_count_w'(scan_divide - 1);

    // Equal button samples needed before the level flips
    localparam int debounce_samples = 4;

    // Active low, bit 7 is the decimal point, bits 6..0 are g..a
    function automatic logic [7:0] segment_code(input nibble_t value);
        logic [7:0] code;
        case (value)
            4'h0:    code = 8'hC0;
            4'h1:    code = 8'hF9;
            4'h2:    code = 8'hA4;
            4'h3:    code = 8'hB0;
            4'h4:    code = 8'h99;
            4'h5:    code = 8'h92;
            4'h6:    code = 8'h82;
            4'h7:    code = 8'hF8;
            4'h8:    code = 8'h80;
            4'h9:    code = 8'h90;
            4'hA:    code = 8'h88;
            4'hB:    code = 8'h83;
            4'hC:    code = 8'hC6;
            4'hD:    code = 8'hA1;
            4'hE:    code = 8'h86;
            default: code = 8'h8E;
        endcase
        return code;
    endfunction

endpackage
